// ==== proc.f ====
+incdir+.
rtl/proc_pkg.sv
rtl/fetch.sv
rtl/hdu.sv
rtl/decode.sv
rtl/execute.sv
rtl/memory.sv
rtl/host_apb.sv
rtl/proc.sv
sim/proc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module proc_tb \
   -f proc.f \
   -o proc_tb_sim

# The simulator exits nonzero on a fatal error, the log decides
./obj_dir/proc_tb_sim 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
   echo "Test failed, see sim.log"
   exit 1
fi

if ! grep -q "SIMULATION PASSED" sim.log; then
   echo "Test ended without a result, see sim.log"
   exit 1
fi

echo "Test passed"

// ==== sim/proc_tb.sv ====
// Pipelined core testbench
`timescale 1ns/100ps
`include "proc_defs.svh"

module proc_tb;

   localparam int N_PROGS      = 8;
   localparam int BODY_START   = 9;    // After the r0 clear and the eight seeds
   localparam int BODY_LEN     = 40;
   localparam int STORE_START  = BODY_START + BODY_LEN;
   localparam int PROG_LEN     = STORE_START + 10;   // Stores, HALT, trailing store
   localparam int APB_PER_PROG = 600;
   localparam longint WATCHDOG_NS = N_PROGS * (4 * PROG_LEN + 3 * APB_PER_PROG + 500) * 20;

   localparam logic [4:0] OP_HALT = 5'b00000;
   localparam logic [4:0] OP_J    = 5'b00100;
   localparam logic [4:0] OP_ADDI = 5'b01000;
   localparam logic [4:0] OP_BEQZ = 5'b01100;
   localparam logic [4:0] OP_BNEZ = 5'b01101;
   localparam logic [4:0] OP_ST   = 5'b10000;
   localparam logic [4:0] OP_LD   = 5'b10001;
   localparam logic [4:0] OP_RRR  = 5'b11011;

   localparam logic [`APB_ADDR_W-1:0] CTRL_ADDR = 12'h800;

   logic               clk;
   logic               rst_n;
   proc_pkg::apb_req_t apb_req;
   logic [`DATA_W-1:0] prdata;
   logic               pslverr;

   logic [31:0]        lfsr;
   logic [`DATA_W-1:0] prog [64];
   logic [`DATA_W-1:0] mdl_rf [8];
   logic [`DATA_W-1:0] mdl_mem [`DMEM_WORDS];
   logic [`DATA_W-1:0] got_mem [`DMEM_WORDS];   // Data memory as read back
   event               compare_start;
   int                 compares_done;

   proc proc_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .apb_req (apb_req),
      .prdata  (prdata),
      .pslverr (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      int          b;
      v = '0;
      for (b = 0; b < n; b++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[14:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [15:0] enc_r(input logic [2:0] rs, input logic [2:0] rt,
                                         input logic [2:0] rd, input logic [1:0] func);
      return {OP_RRR, rs, rt, rd, func};
   endfunction

   function automatic logic [15:0] enc_i(input logic [4:0] op, input logic [2:0] rs,
                                         input logic [2:0] rd, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [11:0] dmem_addr(input logic [7:0] idx);
      return {2'b01, idx, 2'b00};
   endfunction

   function automatic logic [11:0] imem_addr(input logic [7:0] idx);
      return {2'b00, idx, 2'b00};
   endfunction

   task automatic abort_run();
      $display("SIMULATION FAILED");
      $fatal(1, "Stopping at the first error");
   endtask

   task automatic check_value(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
      assert (got === exp) else begin
         $display("error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   // One zero-wait APB transfer sampled mid access phase
   task automatic apb_xfer(input logic write, input logic [11:0] addr,
                           input logic [15:0] wdata, input logic exp_err,
                           output logic [15:0] rdata);
      logic err;
      @(posedge clk);
      #2;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(posedge clk);
      #2 apb_req.penable = 1'b1;
      @(negedge clk);
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #2;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
      assert (err == exp_err) else begin
         $display("error at %0t ns: pslverr %0b at address %h, expected %0b",
                  $time, err, addr, exp_err);
         abort_run();
      end
   endtask

   task automatic gen_program();
      int         i;
      int         k;
      int         skip;
      logic [2:0] kind;
      logic [2:0] ra;
      logic [2:0] rb;
      logic [2:0] rc;
      logic [4:0] imm;
      prog[0] = enc_r(3'd0, 3'd0, 3'd0, 2'b11);   // XOR clears r0 before the seeds
      for (k = 0; k < 8; k++)
         prog[6'(1 + k)] = enc_i(OP_ADDI, 3'd0, 3'(k), 5'(rand_bits(5)));
      for (i = BODY_START; i < STORE_START; i++) begin
         kind = 3'(rand_bits(3));
         ra   = 3'(rand_bits(3));
         rb   = 3'(rand_bits(3));
         rc   = 3'(rand_bits(3));
         imm  = 5'(rand_bits(5));
         skip = int'(rand_bits(2));
         if (skip > STORE_START - i - 1)
            skip = STORE_START - i - 1;   // Never past the final stores
         case (kind)
            3'd0, 3'd1: prog[6'(i)] = enc_r(ra, rb, rc, imm[1:0]);
            3'd2:       prog[6'(i)] = enc_i(OP_ADDI, ra, rb, imm);
            3'd3:       prog[6'(i)] = enc_i(OP_LD, ra, rb, imm);
            3'd4:       prog[6'(i)] = enc_i(OP_ST, ra, rb, imm);
            3'd5:       prog[6'(i)] = {OP_BEQZ, ra, 8'(2 * skip)};
            3'd6:       prog[6'(i)] = {OP_BNEZ, ra, 8'(2 * skip)};
            default:    prog[6'(i)] = {OP_J, 11'(2 * skip)};
         endcase
      end
      for (k = 0; k < 8; k++)
         prog[6'(STORE_START + k)] = enc_i(OP_ST, 3'd0, 3'(k), 5'(2 * k));
      prog[6'(STORE_START + 8)] = {OP_HALT, 11'd0};
      prog[6'(STORE_START + 9)] = enc_i(OP_ST, 3'd0, 3'd1, 5'h1e);   // Dead store
   endtask

   // Instruction-level model that always ends since branches only go forward
   function automatic void run_model();
      logic [15:0] pc;
      logic [15:0] w;
      logic [15:0] ea;
      logic [15:0] imm8;
      logic [2:0]  rs;
      logic [2:0]  rt;
      logic [2:0]  rd;
      int          steps;
      pc = '0;
      for (steps = 0; steps < PROG_LEN; steps++) begin
         w    = prog[pc[6:1]];
         rs   = w[10:8];
         rt   = w[7:5];
         rd   = w[4:2];
         imm8 = {{8{w[7]}}, w[7:0]};
         ea   = mdl_rf[rs] + {{11{w[4]}}, w[4:0]};
         pc   = pc + 16'd2;
         case (w[15:11])
            OP_HALT: return;
            OP_ADDI: mdl_rf[rt] = ea;
            OP_LD:   mdl_rf[rt] = mdl_mem[ea[8:1]];
            OP_ST:   mdl_mem[ea[8:1]] = mdl_rf[rt];
            OP_BEQZ: pc = (mdl_rf[rs] == '0) ? pc + imm8 : pc;
            OP_BNEZ: pc = (mdl_rf[rs] != '0) ? pc + imm8 : pc;
            OP_J:    pc = pc + {{5{w[10]}}, w[10:0]};
            OP_RRR: begin
               case (w[1:0])
                  2'b00:   mdl_rf[rd] = mdl_rf[rs] + mdl_rf[rt];
                  2'b01:   mdl_rf[rd] = mdl_rf[rs] - mdl_rf[rt];
                  2'b10:   mdl_rf[rd] = mdl_rf[rs] & mdl_rf[rt];
                  default: mdl_rf[rd] = mdl_rf[rs] ^ mdl_rf[rt];
               endcase
            end
            default: ;
         endcase
      end
   endfunction

   task automatic load_memories(input int p);
      logic [15:0] rd;
      logic [7:0]  idx;
      int          i;
      for (i = 0; i < `DMEM_WORDS; i++) begin
         idx          = 8'(i);
         mdl_mem[idx] = {idx, ~idx} ^ (16'h1111 * 16'(p + 1));
         apb_xfer(1'b1, dmem_addr(idx), mdl_mem[idx], 1'b0, rd);
      end
      for (i = 0; i < PROG_LEN; i++)
         apb_xfer(1'b1, imem_addr(8'(i)), prog[6'(i)], 1'b0, rd);
   endtask

   task automatic wait_halted();
      logic [15:0] rd;
      rd = '0;
      while (!rd[1])
         apb_xfer(1'b0, CTRL_ADDR, '0, 1'b0, rd);
      check_value("run bit at halt", {15'd0, rd[0]}, 16'h0001);
   endtask

   initial begin : compare_proc
      int i;
      compares_done = 0;
      forever begin
         @(compare_start);
         for (i = 0; i < `DMEM_WORDS; i++)
            check_value($sformatf("dmem[%0d]", i), got_mem[8'(i)], mdl_mem[8'(i)]);
         compares_done++;
      end
   end

   initial begin : main_seq
      logic [15:0] rd;
      int          p;
      int          i;
      rst_n   = 1'b0;
      apb_req = '0;
      lfsr    = 32'h913c_17a9;
      for (i = 0; i < 8; i++)
         mdl_rf[3'(i)] = '0;
      repeat (3) @(posedge clk);
      #2 rst_n = 1'b1;

      apb_xfer(1'b0, CTRL_ADDR, '0, 1'b0, rd);
      check_value("control after reset", rd, 16'h0000);

      for (p = 0; p < N_PROGS; p++) begin
         gen_program();
         load_memories(p);
         if (p == 0) begin
            for (i = 0; i < 16; i++) begin
               apb_xfer(1'b0, dmem_addr(8'(i)), '0, 1'b0, rd);
               check_value("dmem readback", rd, mdl_mem[8'(i)]);
            end
            for (i = 0; i < PROG_LEN; i++) begin
               apb_xfer(1'b0, imem_addr(8'(i)), '0, 1'b0, rd);
               check_value("imem readback", rd, prog[6'(i)]);
            end
         end
         run_model();
         apb_xfer(1'b1, CTRL_ADDR, 16'h0001, 1'b0, rd);
         apb_xfer(1'b0, dmem_addr(8'd5), '0, 1'b1, rd);
         check_value("dmem while running", rd, 16'h0000);
         wait_halted();
         // Memories stay locked while halted with run set
         apb_xfer(1'b1, dmem_addr(8'd5), ~mdl_mem[8'd5], 1'b1, rd);
         apb_xfer(1'b1, CTRL_ADDR, 16'h0000, 1'b0, rd);
         apb_xfer(1'b0, CTRL_ADDR, '0, 1'b0, rd);
         check_value("control after stop", rd, 16'h0002);
         for (i = 0; i < `DMEM_WORDS; i++)
            apb_xfer(1'b0, dmem_addr(8'(i)), '0, 1'b0, got_mem[8'(i)]);
         -> compare_start;
         wait (compares_done == p + 1);
      end
      $display("SIMULATION PASSED");
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog expired, the core never halted or the host port hung");
      $display("SIMULATION FAILED");
      $fatal(1, "Run ended by the watchdog");
   end

endmodule

// ==== rtl/proc.sv ====
// Five-stage processor core
`timescale 1ns/100ps
`include "proc_defs.svh"

module proc (
   input  logic               clk,
   input  logic               rst_n,
   input  proc_pkg::apb_req_t apb_req,
   output logic [`DATA_W-1:0] prdata,
   output logic               pslverr
);

   logic                run;
   logic                stall;
   proc_pkg::redirect_t redirect;
   proc_pkg::host_mem_t imem_wr;
   proc_pkg::host_mem_t dmem_wr;
   logic [`DATA_W-1:0]  imem_rdata;
   logic [`DATA_W-1:0]  dmem_rdata;
   proc_pkg::fd_t       fd;
   proc_pkg::de_t       de;
   proc_pkg::em_t       em;
   proc_pkg::mw_t       mw;

   fetch fetch_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .stall      (stall),
      .redirect   (redirect),
      .imem_wr    (imem_wr),
      .imem_rdata (imem_rdata),
      .fd         (fd)
   );

   hdu hdu_i (
      .fd    (fd),
      .de    (de),
      .em    (em),
      .stall (stall)
   );

   decode decode_i (
      .clk   (clk),
      .rst_n (rst_n),
      .run   (run),
      .stall (stall),
      .flush (redirect.taken),   // Branch in execute squashes decode
      .fd    (fd),
      .mw    (mw),
      .de    (de)
   );

   execute execute_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .run      (run),
      .de       (de),
      .em       (em),
      .redirect (redirect)
   );

   memory memory_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .em         (em),
      .dmem_wr    (dmem_wr),
      .dmem_rdata (dmem_rdata),
      .mw         (mw)
   );

   host_apb host_apb_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .apb_req    (apb_req),
      .imem_rdata (imem_rdata),
      .dmem_rdata (dmem_rdata),
      .mw         (mw),
      .prdata     (prdata),
      .pslverr    (pslverr),
      .run        (run),
      .imem_wr    (imem_wr),
      .dmem_wr    (dmem_wr)
   );

endmodule

// ==== rtl/host_apb.sv ====
// APB host port and run control
`timescale 1ns/100ps
`include "proc_defs.svh"

module host_apb (
   input  logic                clk,
   input  logic                rst_n,
   input  proc_pkg::apb_req_t  apb_req,
   input  logic [`DATA_W-1:0]  imem_rdata,
   input  logic [`DATA_W-1:0]  dmem_rdata,
   input  proc_pkg::mw_t       mw,
   output logic [`DATA_W-1:0]  prdata,
   output logic                pslverr,
   output logic                run,
   output proc_pkg::host_mem_t imem_wr,
   output proc_pkg::host_mem_t dmem_wr
);

   localparam logic [1:0] REGION_IMEM = 2'b00;
   localparam logic [1:0] REGION_DMEM = 2'b01;
   localparam logic [1:0] REGION_CTRL = 2'b10;

   logic                  access;
   logic [1:0]            region;
   logic [`MEM_IDX_W-1:0] idx;
   logic                  mem_wr;
   logic                  halted;

   assign access = apb_req.psel && apb_req.penable;   // Zero wait access phase
   assign region = apb_req.paddr[`APB_ADDR_W-1:`APB_ADDR_W-2];
   assign idx    = apb_req.paddr[`MEM_IDX_W+1:2];
   assign mem_wr = access && apb_req.pwrite && !run;

   assign imem_wr = '{we: mem_wr && region == REGION_IMEM, idx: idx, wdata: apb_req.pwdata};
   assign dmem_wr = '{we: mem_wr && region == REGION_DMEM, idx: idx, wdata: apb_req.pwdata};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run    <= 1'b0;
         halted <= 1'b0;
      end else begin
         if (mw.valid && mw.is_halt)
            halted <= 1'b1;
         if (access && apb_req.pwrite && region == REGION_CTRL) begin
            run <= apb_req.pwdata[0];
            if (apb_req.pwdata[0] && !run)
               halted <= 1'b0;   // Fresh start
         end
      end
   end

   always_comb begin
      case (region)
         REGION_IMEM: prdata = run ? '0 : imem_rdata;
         REGION_DMEM: prdata = run ? '0 : dmem_rdata;
         REGION_CTRL: prdata = {{(`DATA_W-2){1'b0}}, halted, run};
         default:     prdata = '0;
      endcase
   end

   // Memories are locked while the core runs
   assign pslverr = access && run && (region == REGION_IMEM || region == REGION_DMEM);

endmodule

// ==== rtl/memory.sv ====
// Memory stage with writeback select
`timescale 1ns/100ps
`include "proc_defs.svh"

module memory (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                run,
   input  proc_pkg::em_t       em,
   input  proc_pkg::host_mem_t dmem_wr,
   output logic [`DATA_W-1:0]  dmem_rdata,
   output proc_pkg::mw_t       mw
);

   logic [`DATA_W-1:0]    dmem [`DMEM_WORDS];
   logic [`MEM_IDX_W-1:0] addr_idx;
   logic [`DATA_W-1:0]    load_data;
   logic [`DATA_W-1:0]    wdata;
   logic                  store_en;

   assign addr_idx   = em.result[`MEM_IDX_W:1];   // Byte address to word
   assign store_en   = run && em.valid && em.mem_write;
   assign load_data  = dmem[addr_idx];
   assign dmem_rdata = dmem[dmem_wr.idx];

   // Host only writes while the core is stopped
   always_ff @(posedge clk) begin
      if (dmem_wr.we)
         dmem[dmem_wr.idx] <= dmem_wr.wdata;
      else if (store_en)
         dmem[addr_idx] <= em.store_data;
   end

   assign wdata = em.mem_read ? load_data : em.result;   // Writeback select

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mw <= '0;
      end else if (!run || !em.valid) begin
         mw <= '0;
      end else begin
         mw <= '{valid: 1'b1, reg_write: em.reg_write, wsel: em.wsel, wdata: wdata,
                 is_halt: em.is_halt};
      end
   end

endmodule

// ==== rtl/execute.sv ====
// Execute stage
`timescale 1ns/100ps
`include "proc_defs.svh"

module execute (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                run,
   input  proc_pkg::de_t       de,
   output proc_pkg::em_t       em,
   output proc_pkg::redirect_t redirect
);

   logic [`DATA_W-1:0] op_b;
   logic [`DATA_W-1:0] result;
   logic               rs_zero;

   assign op_b = de.ctrl.alu_src_imm ? de.imm : de.rt_val;

   always_comb begin
      case (de.ctrl.alu_op)
         proc_pkg::ALU_ADD: result = de.rs_val + op_b;   // Also load/store address
         proc_pkg::ALU_SUB: result = de.rs_val - op_b;
         proc_pkg::ALU_AND: result = de.rs_val & op_b;
         proc_pkg::ALU_XOR: result = de.rs_val ^ op_b;
         default:           result = de.rs_val;
      endcase
   end

   // Branch and jump resolve here
   assign rs_zero         = (de.rs_val == '0);
   assign redirect.target = de.pc_next + de.imm;
   assign redirect.taken  = de.valid && (de.ctrl.is_jump ||
                                         (de.ctrl.is_beqz && rs_zero) ||
                                         (de.ctrl.is_bnez && !rs_zero));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         em <= '0;
      else if (!run || !de.valid)
         em <= '0;
      else
         em <= '{valid: 1'b1, reg_write: de.ctrl.reg_write, mem_read: de.ctrl.mem_read,
                 mem_write: de.ctrl.mem_write, is_halt: de.ctrl.is_halt, result: result,
                 store_data: de.rt_val, wsel: de.wsel};
   end

endmodule

// ==== rtl/decode.sv ====
// Decode stage and register file
`timescale 1ns/100ps
`include "proc_defs.svh"

module decode (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          run,
   input  logic          stall,
   input  logic          flush,
   input  proc_pkg::fd_t fd,
   input  proc_pkg::mw_t mw,
   output proc_pkg::de_t de
);

   localparam logic [`DATA_W-1:0] PC_STEP = 16'd2;

   logic [`DATA_W-1:0]     rf [`NUM_REGS];
   proc_pkg::ctrl_t        ctrl;
   logic [`REG_ADDR_W-1:0] wsel;
   logic [`DATA_W-1:0]     imm;
   logic [`DATA_W-1:0]     rs_val;
   logic [`DATA_W-1:0]     rt_val;
   logic                   wb_en;

   always_comb begin
      ctrl        = '0;
      ctrl.alu_op = proc_pkg::ALU_PASS_A;
      wsel        = fd.instr.i.rd;   // ADDI and LD
      imm         = {{(`DATA_W-5){fd.instr.i.imm5[4]}}, fd.instr.i.imm5};
      case (fd.instr.r.opcode)
         proc_pkg::OP_RRR: begin
            ctrl.reg_write = 1'b1;
            wsel           = fd.instr.r.rd;
            case (fd.instr.r.func)
               2'b00:   ctrl.alu_op = proc_pkg::ALU_ADD;
               2'b01:   ctrl.alu_op = proc_pkg::ALU_SUB;
               2'b10:   ctrl.alu_op = proc_pkg::ALU_AND;
               default: ctrl.alu_op = proc_pkg::ALU_XOR;
            endcase
         end
         proc_pkg::OP_ADDI: begin
            ctrl.reg_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.alu_op      = proc_pkg::ALU_ADD;
         end
         proc_pkg::OP_LD: begin
            ctrl.reg_write   = 1'b1;
            ctrl.mem_read    = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.alu_op      = proc_pkg::ALU_ADD;
         end
         proc_pkg::OP_ST: begin
            ctrl.mem_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.alu_op      = proc_pkg::ALU_ADD;
         end
         proc_pkg::OP_BEQZ: begin
            ctrl.is_beqz = 1'b1;
            imm          = {{(`DATA_W-8){fd.instr.b.imm8[7]}}, fd.instr.b.imm8};
         end
         proc_pkg::OP_BNEZ: begin
            ctrl.is_bnez = 1'b1;
            imm          = {{(`DATA_W-8){fd.instr.b.imm8[7]}}, fd.instr.b.imm8};
         end
         proc_pkg::OP_J: begin
            ctrl.is_jump = 1'b1;
            imm          = {{(`DATA_W-11){fd.instr.j.disp11[10]}}, fd.instr.j.disp11};
         end
         proc_pkg::OP_HALT: ctrl.is_halt = 1'b1;
         default: ;   // NOP and unused opcodes
      endcase
   end

   assign wb_en = mw.valid && mw.reg_write;

   // Same-cycle writeback is visible to the read ports
   assign rs_val = (wb_en && mw.wsel == fd.instr.r.rs) ? mw.wdata : rf[fd.instr.r.rs];
   assign rt_val = (wb_en && mw.wsel == fd.instr.r.rt) ? mw.wdata : rf[fd.instr.r.rt];

   always_ff @(posedge clk) begin
      if (wb_en)
         rf[mw.wsel] <= mw.wdata;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         de <= '0;
      else if (!run || stall || flush || !fd.valid)
         de <= '0;   // Bubble
      else
         de <= '{valid: 1'b1, ctrl: ctrl, pc_next: fd.pc + PC_STEP, rs_val: rs_val,
                 rt_val: rt_val, imm: imm, wsel: wsel};
   end

endmodule

// ==== rtl/hdu.sv ====
// Data hazard detection
`timescale 1ns/100ps
`include "proc_defs.svh"

module hdu (
   input  proc_pkg::fd_t fd,
   input  proc_pkg::de_t de,
   input  proc_pkg::em_t em,
   output logic          stall
);

   logic                   uses_rs;
   logic                   uses_rt;   // Also the ST data register at [7:5]
   logic [`REG_ADDR_W-1:0] rs;
   logic [`REG_ADDR_W-1:0] rt;
   logic                   de_wr;
   logic                   em_wr;
   logic                   rs_busy;
   logic                   rt_busy;

   assign rs = fd.instr.r.rs;
   assign rt = fd.instr.r.rt;

   always_comb begin
      uses_rs = 1'b0;
      uses_rt = 1'b0;
      case (fd.instr.r.opcode)
         proc_pkg::OP_RRR,
         proc_pkg::OP_ST: begin
            uses_rs = 1'b1;
            uses_rt = 1'b1;
         end
         proc_pkg::OP_ADDI,
         proc_pkg::OP_LD,
         proc_pkg::OP_BEQZ,
         proc_pkg::OP_BNEZ: uses_rs = 1'b1;
         default: ;
      endcase
   end

   // Writers still ahead of the register file
   assign de_wr = de.valid && de.ctrl.reg_write;
   assign em_wr = em.valid && em.reg_write;

   assign rs_busy = (de_wr && de.wsel == rs) || (em_wr && em.wsel == rs);
   assign rt_busy = (de_wr && de.wsel == rt) || (em_wr && em.wsel == rt);

   assign stall = fd.valid && ((uses_rs && rs_busy) || (uses_rt && rt_busy));

endmodule

// ==== rtl/fetch.sv ====
// Fetch stage
`timescale 1ns/100ps
`include "proc_defs.svh"

module fetch (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                run,
   input  logic                stall,
   input  proc_pkg::redirect_t redirect,
   input  proc_pkg::host_mem_t imem_wr,
   output logic [`DATA_W-1:0]  imem_rdata,
   output proc_pkg::fd_t       fd
);

   localparam logic [`DATA_W-1:0] PC_STEP = 16'd2;

   logic [`DATA_W-1:0] imem [`IMEM_WORDS];
   logic [`DATA_W-1:0] pc;
   logic               frozen;   // HALT fetched, wait for redirect or stop
   proc_pkg::instr_u   cur;

   assign cur        = imem[pc[`MEM_IDX_W:1]];   // Word index from byte PC
   assign imem_rdata = imem[imem_wr.idx];

   always_ff @(posedge clk) begin
      if (imem_wr.we)
         imem[imem_wr.idx] <= imem_wr.wdata;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc     <= '0;
         frozen <= 1'b0;
         fd     <= '0;
      end else if (!run) begin
         pc     <= '0;   // Restart point
         frozen <= 1'b0;
         fd     <= '0;
      end else if (redirect.taken) begin
         pc     <= redirect.target;
         frozen <= 1'b0;
         fd     <= '0;   // Younger instruction squashed
      end else if (!stall) begin
         if (frozen) begin
            fd <= '0;
         end else begin
            fd     <= '{valid: 1'b1, pc: pc, instr: cur};
            pc     <= pc + PC_STEP;
            frozen <= (cur.r.opcode == proc_pkg::OP_HALT);
         end
      end
   end

endmodule

// ==== rtl/proc_pkg.sv ====
// Processor core types
`include "proc_defs.svh"

package proc_pkg;

   typedef enum logic [4:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_J    = 5'b00100,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_BNEZ = 5'b01101,
      OP_ST   = 5'b10000,
      OP_LD   = 5'b10001,
      OP_RRR  = 5'b11011
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_PASS_A
   } alu_op_e;

   // Register-register format
   typedef struct packed {
      opcode_e                opcode;
      logic [`REG_ADDR_W-1:0] rs;
      logic [`REG_ADDR_W-1:0] rt;
      logic [`REG_ADDR_W-1:0] rd;
      logic [1:0]             func;
   } r_fmt_t;

   // Immediate format, also used by ST with rd as the data register
   typedef struct packed {
      opcode_e                opcode;
      logic [`REG_ADDR_W-1:0] rs;
      logic [`REG_ADDR_W-1:0] rd;
      logic [4:0]             imm5;
   } i_fmt_t;

   typedef struct packed {
      opcode_e                opcode;
      logic [`REG_ADDR_W-1:0] rs;
      logic [7:0]             imm8;
   } b_fmt_t;

   typedef struct packed {
      opcode_e     opcode;
      logic [10:0] disp11;
   } j_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      b_fmt_t b;
      j_fmt_t j;
   } instr_u;

   typedef struct packed {
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    alu_src_imm;
      alu_op_e alu_op;
      logic    is_beqz;
      logic    is_bnez;
      logic    is_jump;
      logic    is_halt;
   } ctrl_t;

   typedef struct packed {
      logic               valid;
      logic [`DATA_W-1:0] pc;
      instr_u             instr;
   } fd_t;

   typedef struct packed {
      logic                   valid;
      ctrl_t                  ctrl;
      logic [`DATA_W-1:0]     pc_next;
      logic [`DATA_W-1:0]     rs_val;
      logic [`DATA_W-1:0]     rt_val;
      logic [`DATA_W-1:0]     imm;     // Sign extended
      logic [`REG_ADDR_W-1:0] wsel;
   } de_t;

   typedef struct packed {
      logic                   valid;
      logic                   reg_write;
      logic                   mem_read;
      logic                   mem_write;
      logic                   is_halt;
      logic [`DATA_W-1:0]     result;  // ALU result or byte address
      logic [`DATA_W-1:0]     store_data;
      logic [`REG_ADDR_W-1:0] wsel;
   } em_t;

   typedef struct packed {
      logic                   valid;
      logic                   reg_write;
      logic [`REG_ADDR_W-1:0] wsel;
      logic [`DATA_W-1:0]     wdata;
      logic                   is_halt;
   } mw_t;

   typedef struct packed {
      logic               taken;
      logic [`DATA_W-1:0] target;
   } redirect_t;

   typedef struct packed {
      logic                   psel;
      logic                   penable;
      logic                   pwrite;
      logic [`APB_ADDR_W-1:0] paddr;
      logic [`DATA_W-1:0]     pwdata;
   } apb_req_t;

   // Host write into either memory
   typedef struct packed {
      logic                  we;
      logic [`MEM_IDX_W-1:0] idx;
      logic [`DATA_W-1:0]    wdata;
   } host_mem_t;

endpackage

// ==== proc_defs.svh ====
// Processor core sizes
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// Data path and instruction word
`define DATA_W 16

// Register file
`define REG_ADDR_W 3
`define NUM_REGS 8

// Instruction and data memories, in 16-bit words
`define IMEM_WORDS 256
`define DMEM_WORDS 256
`define MEM_IDX_W 8

// Host port
`define APB_ADDR_W 12

`endif
